//--- project.f
source/cache_types_pkg.sv
source/miss_tracker.sv
source/cache_bank.sv
source/ram_port_arbiter.sv
source/banked_cache.sv
tb/tb_ram_model.sv
tb/tb_banked_cache.sv

//--- Makefile
TOP := tb_banked_cache

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f \
		--Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

//--- tb/banked_cache_tests.txt
# name  op  addr  data  uuid  hit  expected   (all numbers in hex)
# hit and expected apply to READ and WRITE, uuid is matched on WAITUUID
rd_miss        READ     00000100 00000000 01 0 00000000
rd_miss_done   WAITUUID 00000100 00000000 01 0 00000000
rd_replay      READ     00000100 00000000 02 1 a5a50100
rd_replay_w3   READ     0000010c 00000000 03 1 a5a5010c
wr_hit         WRITE    00000104 12345678 04 1 00000000
wr_hit_read    READ     00000104 00000000 05 1 12345678
mg_miss        READ     00000210 00000000 10 0 00000000
mg_store       WRITE    00000218 cafef00d 11 0 00000000
mg_done        WAITUUID 00000210 00000000 10 0 00000000
mg_merged      READ     00000218 00000000 12 1 cafef00d
mg_w0          READ     00000210 00000000 13 1 a5a50210
mg_w1          READ     00000214 00000000 14 1 a5a50214
mg_w3          READ     0000021c 00000000 15 1 a5a5021c
ev_store       WRITE    00001060 dead0001 20 0 00000000
ev_store_done  WAITUUID 00001060 00000000 20 0 00000000
ev_store_hit   READ     00001060 00000000 21 1 dead0001
ev_fill1       READ     00001160 00000000 22 0 00000000
ev_fill1_done  WAITUUID 00001160 00000000 22 0 00000000
ev_fill2       READ     00001260 00000000 23 0 00000000
ev_fill2_done  WAITUUID 00001260 00000000 23 0 00000000
ev_gone        READ     00001060 00000000 24 0 00000000
ev_gone_done   WAITUUID 00001060 00000000 24 0 00000000
ev_back        READ     00001060 00000000 25 1 dead0001
ev_back_w1     READ     00001064 00000000 26 1 a5a51064
both_b0        READ     00003020 00000000 30 0 00000000
both_b1        READ     00003130 00000000 31 0 00000000
both_b0_done   WAITUUID 00003020 00000000 30 0 00000000
both_b1_done   WAITUUID 00003130 00000000 31 0 00000000
both_b0_hit    READ     00003028 00000000 32 1 a5a53028
both_b1_hit    READ     0000313c 00000000 33 1 a5a5313c

//--- tb/tb_banked_cache.sv
`default_nettype none

module tb_banked_cache;

    localparam int NUM_WAYS          = 2;
    localparam int NUM_SETS_PER_BANK = 8;
    localparam int CYCLES_PER_LINE   = 200;

    logic                         CLK;
    logic                         nRST;
    logic                         req_valid;
    logic                         req_ready;
    cache_types_pkg::mem_instr_t  req;
    cache_types_pkg::cache_resp_t resp_bank0;
    cache_types_pkg::cache_resp_t resp_bank1;
    cache_types_pkg::wb_req_t     wb_out;
    cache_types_pkg::wb_rsp_t     wb_in;

    string       names[$];
    string       ops[$];
    logic [31:0] addrs[$];
    logic [31:0] datas[$];
    logic [7:0]  uuids[$];
    logic        hits[$];
    logic [31:0] expects[$];

    // finished fills seen on each bank, oldest first
    cache_types_pkg::cache_resp_t done0[$];
    cache_types_pkg::cache_resp_t done1[$];
    bit loaded = 1'b0;

    banked_cache #(
        .NUM_WAYS          (NUM_WAYS),
        .NUM_SETS_PER_BANK (NUM_SETS_PER_BANK)
    ) i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_bank0 (resp_bank0),
        .resp_bank1 (resp_bank1),
        .wb_out     (wb_out),
        .wb_in      (wb_in)
    );

    tb_ram_model i_ram (
        .CLK    (CLK),
        .nRST   (nRST),
        .wb_req (wb_out),
        .wb_rsp (wb_in)
    );

    initial begin : clock_gen
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(negedge CLK) begin : uuid_monitor
        if (nRST && resp_bank0.uuid_ready) begin
            done0.push_back(resp_bank0);
        end
        if (nRST && resp_bank1.uuid_ready) begin
            done1.push_back(resp_bank1);
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // ########################################################################
    // compare tasks
    // ########################################################################
    task automatic check_resp(input string name, input cache_types_pkg::cache_resp_t exp,
                              input cache_types_pkg::cache_resp_t act, input logic with_data);
        if (act.hit !== exp.hit) begin
            stop_run($sformatf("[FAIL] %s: hit expected %0b, actual %0b",
                               name, exp.hit, act.hit));
        end
        if (with_data && act.data !== exp.data) begin
            stop_run($sformatf("[FAIL] %s: data expected %h, actual %h",
                               name, exp.data, act.data));
        end
    endtask

    task automatic check_uuid(input string name, input cache_types_pkg::cache_resp_t exp,
                              input cache_types_pkg::cache_resp_t act);
        if (act.uuid_ready !== exp.uuid_ready) begin
            stop_run($sformatf("[FAIL] %s: uuid_ready expected %0b, actual %0b",
                               name, exp.uuid_ready, act.uuid_ready));
        end
        if (exp.uuid_ready && act.uuid !== exp.uuid) begin
            stop_run($sformatf("[FAIL] %s: uuid expected %h, actual %h",
                               name, exp.uuid, act.uuid));
        end
    endtask

    task automatic check_wb(input string name, input cache_types_pkg::wb_req_t exp,
                            input cache_types_pkg::wb_req_t act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: wishbone request expected %h, actual %h",
                               name, exp, act));
        end
    endtask

    // ########################################################################
    // vectors and stimulus
    // ########################################################################
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [7:0]  uuid;
        logic        hit;
        logic [31:0] exp;
        fd = $fopen("tb/banked_cache_tests.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the test vector file tb/banked_cache_tests.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, data, uuid, hit, exp);
                if (n != 7) begin
                    stop_run({"badly formed test vector line: ", line});
                end
                names.push_back(name);
                ops.push_back(op);
                addrs.push_back(addr);
                datas.push_back(data);
                uuids.push_back(uuid);
                hits.push_back(hit);
                expects.push_back(exp);
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            stop_run("the test vector file holds no tests");
        end
    endtask

    task automatic run_access(input int i);
        cache_types_pkg::mem_instr_t  instr;
        cache_types_pkg::cache_resp_t exp;
        cache_types_pkg::cache_resp_t act;
        instr.addr        = addrs[i];
        instr.store_value = datas[i];
        instr.uuid        = uuids[i];
        if (ops[i] == "WRITE") begin
            instr.rw = cache_types_pkg::WRITE;
        end else begin
            instr.rw = cache_types_pkg::READ;
        end
        exp      = '0;
        exp.hit  = hits[i];
        exp.data = expects[i];
        @(posedge CLK);
        req_valid <= 1'b1;
        req       <= instr;
        @(negedge CLK);
        // held while the bank's tracker owns another block
        while (!req_ready) begin
            @(negedge CLK);
        end
        act = instr.addr.index[0] ? resp_bank1 : resp_bank0;
        check_resp(names[i], exp, act, instr.rw == cache_types_pkg::READ && hits[i]);
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    task automatic wait_uuid(input int i);
        cache_types_pkg::addr_t       a;
        cache_types_pkg::cache_resp_t exp;
        cache_types_pkg::cache_resp_t act;
        a              = addrs[i];
        exp            = '0;
        exp.uuid_ready = 1'b1;
        exp.uuid       = uuids[i];
        if (a.index[0]) begin
            while (done1.size() == 0) begin
                @(negedge CLK);
            end
            act = done1.pop_front();
        end else begin
            while (done0.size() == 0) begin
                @(negedge CLK);
            end
            act = done0.pop_front();
        end
        check_uuid(names[i], exp, act);
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (names.size() * CYCLES_PER_LINE) @(posedge CLK);
        stop_run($sformatf("timeout: tests still running after %0d cycles",
                           names.size() * CYCLES_PER_LINE));
    end

    initial begin : stimulus
        nRST      <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        load_vectors();
        loaded = 1'b1;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_resp("reset", '0, resp_bank0, 1'b0);
        check_resp("reset", '0, resp_bank1, 1'b0);
        check_uuid("reset", '0, resp_bank0);
        check_uuid("reset", '0, resp_bank1);
        check_wb("reset", '0, wb_out);
        for (int i = 0; i < names.size(); i++) begin
            if (ops[i] == "WAITUUID") begin
                wait_uuid(i);
            end else if (ops[i] == "READ" || ops[i] == "WRITE") begin
                run_access(i);
            end else begin
                stop_run({"unknown operation ", ops[i], " in test ", names[i]});
            end
        end
        @(negedge CLK);
        check_wb("idle_at_end", '0, wb_out);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_ram_model.sv
`default_nettype none

module tb_ram_model (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cache_types_pkg::wb_req_t wb_req,
    output cache_types_pkg::wb_rsp_t wb_rsp
);

    localparam logic [31:0] FILL_MASK = 32'hA5A5_0000;

    // written words only, everything else reads as the fill pattern
    logic [31:0] mem [logic [31:0]];
    integer      seed = 32'h7970_92df;
    logic        counting;
    logic [1:0]  wait_cnt;

    function automatic logic [31:0] stored_word(input logic [31:0] adr);
        if (mem.exists(adr)) begin
            return mem[adr];
        end
        return adr ^ FILL_MASK;
    endfunction

    // ########################################################################
    // classic slave, one word per ack
    // ########################################################################
    always @(posedge CLK or negedge nRST) begin : slave
        if (!nRST) begin
            counting     <= 1'b0;
            wait_cnt     <= 2'd0;
            wb_rsp.ack   <= 1'b0;
            wb_rsp.dat_r <= '0;
        end else begin
            wb_rsp.ack <= 1'b0;
            if (!(wb_req.cyc && wb_req.stb) || wb_rsp.ack) begin
                counting <= 1'b0;
            end else if (!counting) begin
                // new transfer, 1 to 3 cycles until ack
                counting <= 1'b1;
                wait_cnt <= 2'($unsigned($random(seed)) % 3);
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                counting   <= 1'b0;
                wb_rsp.ack <= 1'b1;
                if (wb_req.we) begin
                    mem[wb_req.adr] = wb_req.dat_w;
                end else begin
                    wb_rsp.dat_r <= stored_word(wb_req.adr);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/banked_cache.sv
`default_nettype none

module banked_cache #(
    parameter int NUM_WAYS          = 2,
    parameter int NUM_SETS_PER_BANK = 8
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         req_valid,
    input  cache_types_pkg::mem_instr_t  req,
    output logic                         req_ready,
    output cache_types_pkg::cache_resp_t resp_bank0,
    output cache_types_pkg::cache_resp_t resp_bank1,
    output cache_types_pkg::wb_req_t     wb_out,
    input  cache_types_pkg::wb_rsp_t     wb_in
);

    localparam int BANK_W    = cache_types_pkg::BANKS_LEN;
    localparam int NUM_BANKS = 1 << BANK_W;

    logic [BANK_W-1:0]    bank_sel;
    logic [NUM_BANKS-1:0] instr_valid;
    logic [NUM_BANKS-1:0] miss_valid;
    logic [NUM_BANKS-1:0] fill_done;
    logic [NUM_BANKS-1:0] busy;
    logic [NUM_BANKS-1:0] accept;

    cache_types_pkg::mshr_reg_t   [NUM_BANKS-1:0] mshr;
    cache_types_pkg::cache_resp_t [NUM_BANKS-1:0] resp;
    cache_types_pkg::wb_req_t     [NUM_BANKS-1:0] bank_wb_req;
    cache_types_pkg::wb_rsp_t     [NUM_BANKS-1:0] bank_wb_rsp;

    assign bank_sel  = req.addr.index[BANK_W-1:0];
    assign req_ready = accept[bank_sel];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign instr_valid[b] = req_valid && req_ready && (bank_sel == BANK_W'(b));

        cache_bank #(
            .NUM_WAYS          (NUM_WAYS),
            .NUM_SETS_PER_BANK (NUM_SETS_PER_BANK)
        ) i_bank (
            .CLK          (CLK),
            .nRST         (nRST),
            .instr_valid  (instr_valid[b]),
            .mem_instr_in (req),
            .mshr_entry   (mshr[b]),
            .miss_valid   (miss_valid[b]),
            .fill_done    (fill_done[b]),
            .busy         (busy[b]),
            .resp         (resp[b]),
            .wb_out       (bank_wb_req[b]),
            .wb_in        (bank_wb_rsp[b])
        );

        miss_tracker i_mshr (
            .CLK        (CLK),
            .nRST       (nRST),
            .miss_valid (miss_valid[b]),
            .req        (req),
            .fill_done  (fill_done[b]),
            .accept     (accept[b]),
            .mshr_entry (mshr[b])
        );

        // a bank only works while its tracker holds the miss
        a_busy_has_miss: assert property (@(posedge CLK) disable iff (!nRST)
            busy[b] |-> mshr[b].valid);
    end

    assign resp_bank0 = resp[0];
    assign resp_bank1 = resp[1];

    ram_port_arbiter i_arb (
        .CLK       (CLK),
        .nRST      (nRST),
        .bank_req0 (bank_wb_req[0]),
        .bank_req1 (bank_wb_req[1]),
        .bank_rsp0 (bank_wb_rsp[0]),
        .bank_rsp1 (bank_wb_rsp[1]),
        .wb_out    (wb_out),
        .wb_in     (wb_in)
    );

endmodule

`default_nettype wire

//--- source/ram_port_arbiter.sv
`default_nettype none

module ram_port_arbiter (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cache_types_pkg::wb_req_t bank_req0,
    input  cache_types_pkg::wb_req_t bank_req1,
    output cache_types_pkg::wb_rsp_t bank_rsp0,
    output cache_types_pkg::wb_rsp_t bank_rsp1,
    output cache_types_pkg::wb_req_t wb_out,
    input  cache_types_pkg::wb_rsp_t wb_in
);

    logic owner;
    logic owner_valid;
    logic rr_next;
    logic held;
    logic sel;
    logic grant;
    cache_types_pkg::wb_req_t sel_req;

    // owner keeps the port until it drops cyc
    assign held = owner_valid && (owner ? bank_req1.cyc : bank_req0.cyc);

    always_comb begin : select
        if (held) begin
            sel = owner;
        end else if (rr_next ? bank_req1.cyc : bank_req0.cyc) begin
            sel = rr_next;
        end else begin
            sel = !rr_next;
        end
    end

    assign sel_req = sel ? bank_req1 : bank_req0;
    assign grant   = sel_req.cyc;
    assign wb_out  = grant ? sel_req : '0;

    always_comb begin : route_rsp
        bank_rsp0.dat_r = wb_in.dat_r;
        bank_rsp1.dat_r = wb_in.dat_r;
        bank_rsp0.ack   = grant && !sel && wb_in.ack;
        bank_rsp1.ack   = grant && sel && wb_in.ack;
    end

    always_ff @(posedge CLK, negedge nRST) begin : owner_regs
        if (!nRST) begin
            owner       <= 1'b0;
            owner_valid <= 1'b0;
            rr_next     <= 1'b0;
        end else begin
            owner       <= sel;
            owner_valid <= grant;
            // fresh grant hands priority to the other bank
            if (grant && !held) begin
                rr_next <= !sel;
            end
        end
    end

    a_one_ack: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({bank_rsp0.ack, bank_rsp1.ack}));

    // RAM must not ack an idle bus, or the ack gets lost
    a_ack_owned: assert property (@(posedge CLK) disable iff (!nRST)
        wb_in.ack |-> $onehot({bank_rsp0.ack, bank_rsp1.ack}));

endmodule

`default_nettype wire

//--- source/cache_bank.sv
`default_nettype none

module cache_bank #(
    parameter int NUM_WAYS          = 2,
    parameter int NUM_SETS_PER_BANK = 8
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        instr_valid,
    input  cache_types_pkg::mem_instr_t mem_instr_in,
    input  cache_types_pkg::mshr_reg_t  mshr_entry,
    output logic                        miss_valid,
    output logic                        fill_done,
    output logic                        busy,
    output cache_types_pkg::cache_resp_t resp,
    output cache_types_pkg::wb_req_t    wb_out,
    input  cache_types_pkg::wb_rsp_t    wb_in
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int SET_W = (NUM_SETS_PER_BANK > 1) ? $clog2(NUM_SETS_PER_BANK) : 1;
    localparam int OFF_W = cache_types_pkg::BLOCK_OFF_BIT_LEN;
    localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(cache_types_pkg::BLOCK_SIZE - 1);

    typedef logic [NUM_WAYS-1:0][WAY_W-1:0] age_row_t;
    typedef cache_types_pkg::cache_frame_t [NUM_WAYS-1:0] set_t;

    cache_types_pkg::bank_state_e state, next_state;
    set_t     [NUM_SETS_PER_BANK-1:0] lines, next_lines;
    age_row_t [NUM_SETS_PER_BANK-1:0] ages, next_ages;

    cache_types_pkg::cache_frame_t victim_buf;
    logic [cache_types_pkg::BLOCK_SIZE-1:0][cache_types_pkg::CACHE_RW_SIZE-1:0] pull_buf;
    logic [WAY_W-1:0] victim_way, lru_way, hit_way;
    logic [SET_W-1:0] req_set, fill_set;
    logic [OFF_W-1:0] word_cnt;
    logic             pending;
    logic             hit;
    logic             step;

    assign req_set  = SET_W'(mem_instr_in.addr.index >> cache_types_pkg::BANKS_LEN);
    assign fill_set = SET_W'(mshr_entry.block_addr.index >> cache_types_pkg::BANKS_LEN);

    // move way to age 0, everything younger than it gets one older
    function automatic age_row_t touch(input age_row_t row, input logic [WAY_W-1:0] way);
        age_row_t res;
        res = row;
        for (int j = 0; j < NUM_WAYS; j++) begin
            if (row[j] < row[way]) begin
                res[j] = row[j] + 1'b1;
            end
        end
        res[way] = '0;
        return res;
    endfunction

    // ########################################################################
    // lookup
    // ########################################################################
    always_comb begin : hit_check
        hit     = 1'b0;
        hit_way = '0;
        if (instr_valid) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (lines[req_set][w].valid && lines[req_set][w].tag == mem_instr_in.addr.tag) begin
                    hit     = 1'b1;
                    hit_way = WAY_W'(w);
                end
            end
        end
    end

    always_comb begin : pick_victim
        lru_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ages[fill_set][w] == WAY_W'(NUM_WAYS - 1)) begin
                lru_way = WAY_W'(w);
            end
        end
    end

    assign miss_valid = instr_valid && !hit;
    assign fill_done  = (state == cache_types_pkg::FINISH);
    assign busy       = (state == cache_types_pkg::START) ? mshr_entry.valid : !fill_done;

    always_comb begin : response
        resp.hit        = hit;
        resp.data       = '0;
        resp.uuid_ready = fill_done;
        resp.uuid       = fill_done ? mshr_entry.uuid : '0;
        if (hit && mem_instr_in.rw == cache_types_pkg::READ) begin
            resp.data = lines[req_set][hit_way].block[mem_instr_in.addr.block_offset];
        end
    end

    // ########################################################################
    // fill / evict
    // ########################################################################
    always_comb begin : controller
        next_state = state;
        next_lines = lines;
        next_ages  = ages;
        wb_out     = '0;
        step       = 1'b0;

        if (hit) begin
            next_ages[req_set] = touch(ages[req_set], hit_way);
            if (mem_instr_in.rw == cache_types_pkg::WRITE) begin
                next_lines[req_set][hit_way].block[mem_instr_in.addr.block_offset] =
                    mem_instr_in.store_value;
                next_lines[req_set][hit_way].dirty = 1'b1;
            end
        end

        case (state)
            cache_types_pkg::START: begin
                if (mshr_entry.valid) begin
                    next_lines[fill_set][lru_way].valid = 1'b0;
                    next_state = cache_types_pkg::BLOCK_PULL;
                end
            end
            cache_types_pkg::BLOCK_PULL: begin
                // merged words are skipped unless a read is already on the bus
                wb_out.cyc = pending || !mshr_entry.write_status[word_cnt];
                wb_out.stb = wb_out.cyc;
                wb_out.adr = {mshr_entry.block_addr.tag, mshr_entry.block_addr.index,
                              word_cnt, 2'b00};
                step = !wb_out.stb || wb_in.ack;
                if (step && word_cnt == LAST_WORD) begin
                    next_state = (victim_buf.valid && victim_buf.dirty)
                               ? cache_types_pkg::VICTIM_EJECT : cache_types_pkg::FINISH;
                end
            end
            cache_types_pkg::VICTIM_EJECT: begin
                wb_out.cyc   = 1'b1;
                wb_out.stb   = 1'b1;
                wb_out.we    = 1'b1;
                wb_out.adr   = {victim_buf.tag, mshr_entry.block_addr.index, word_cnt, 2'b00};
                wb_out.dat_w = victim_buf.block[word_cnt];
                step = wb_in.ack;
                if (step && word_cnt == LAST_WORD) begin
                    next_state = cache_types_pkg::FINISH;
                end
            end
            cache_types_pkg::FINISH: begin
                for (int i = 0; i < cache_types_pkg::BLOCK_SIZE; i++) begin
                    next_lines[fill_set][victim_way].block[i] = mshr_entry.write_status[i]
                        ? mshr_entry.write_block[i] : pull_buf[i];
                end
                next_lines[fill_set][victim_way].valid = 1'b1;
                next_lines[fill_set][victim_way].dirty = |mshr_entry.write_status;
                next_lines[fill_set][victim_way].tag   = mshr_entry.block_addr.tag;
                next_ages[fill_set] = touch(next_ages[fill_set], victim_way);
                next_state = cache_types_pkg::START;
            end
            default: next_state = cache_types_pkg::START;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin : control_regs
        if (!nRST) begin
            state    <= cache_types_pkg::START;
            word_cnt <= '0;
            pending  <= 1'b0;
            lines    <= '0;
            for (int s = 0; s < NUM_SETS_PER_BANK; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    ages[s][w] <= WAY_W'(w);
                end
            end
        end else begin
            state   <= next_state;
            lines   <= next_lines;
            ages    <= next_ages;
            pending <= wb_out.stb && !wb_in.ack;
            if (state == cache_types_pkg::START) begin
                word_cnt <= '0;
            end else if (step) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin : fill_buffers
        if (state == cache_types_pkg::START && mshr_entry.valid) begin
            victim_way <= lru_way;
            victim_buf <= lines[fill_set][lru_way];
        end
        if (state == cache_types_pkg::BLOCK_PULL && wb_out.stb && wb_in.ack) begin
            pull_buf[word_cnt] <= wb_in.dat_r;
        end
    end

    a_stb_has_cyc: assert property (@(posedge CLK) disable iff (!nRST)
        wb_out.stb |-> wb_out.cyc);

    // classic handshake, address held until the slave acks
    a_stb_held: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_out.stb && !wb_in.ack) |=> (wb_out.stb && $stable(wb_out.adr)));

endmodule

`default_nettype wire

//--- source/miss_tracker.sv
`default_nettype none

module miss_tracker (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       miss_valid,
    input  cache_types_pkg::mem_instr_t req,
    input  logic                       fill_done,
    output logic                       accept,
    output cache_types_pkg::mshr_reg_t mshr_entry
);

    cache_types_pkg::mshr_reg_t entry, next_entry;
    logic same_block;
    logic is_store;
    logic alloc;
    logic merge;

    assign same_block = (req.addr.tag == entry.block_addr.tag)
                     && (req.addr.index == entry.block_addr.index);
    assign is_store   = (req.rw == cache_types_pkg::WRITE);

    // other blocks wait for the held miss, same block waits out the install
    assign accept     = !entry.valid || (same_block && !fill_done);
    assign mshr_entry = entry;

    assign alloc = miss_valid && !entry.valid;
    assign merge = miss_valid && is_store && (alloc || (entry.valid && same_block));

    always_comb begin : next_entry_logic
        next_entry = entry;

        if (alloc) begin
            next_entry.valid            = 1'b1;
            next_entry.uuid             = req.uuid;
            next_entry.block_addr.tag   = req.addr.tag;
            next_entry.block_addr.index = req.addr.index;
            next_entry.write_status     = '0;
        end

        // stores ride along with the fill
        if (merge) begin
            next_entry.write_status[req.addr.block_offset] = 1'b1;
            next_entry.write_block[req.addr.block_offset]  = req.store_value;
        end

        if (fill_done) begin
            next_entry.valid        = 1'b0;
            next_entry.write_status = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin : entry_reg
        if (!nRST) begin
            entry <= '0;
        end else begin
            entry <= next_entry;
        end
    end

    // bank only finishes a fill it was handed
    a_fill_needs_entry: assert property (@(posedge CLK) disable iff (!nRST)
        fill_done |-> entry.valid);

endmodule

`default_nettype wire

//--- source/cache_types_pkg.sv
`default_nettype none

package cache_types_pkg;

    // ########################################################################
    // geometry
    // ########################################################################
    localparam int BLOCK_SIZE          = 4;
    localparam int BLOCK_OFF_BIT_LEN   = 2;
    localparam int BANKS_LEN           = 1;
    localparam int BLOCK_INDEX_BIT_LEN = 4;
    localparam int TAG_LEN             = 24;
    localparam int UUID_SIZE           = 8;
    localparam int CACHE_RW_SIZE       = 32;

    // word address, low index bits pick the bank
    typedef struct packed {
        logic [TAG_LEN-1:0]             tag;
        logic [BLOCK_INDEX_BIT_LEN-1:0] index;
        logic [BLOCK_OFF_BIT_LEN-1:0]   block_offset;
        logic [1:0]                     byte_off;
    } addr_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } rw_e;

    typedef struct packed {
        addr_t                    addr;
        rw_e                      rw;
        logic [CACHE_RW_SIZE-1:0] store_value;
        logic [UUID_SIZE-1:0]     uuid;
    } mem_instr_t;

    typedef struct packed {
        logic [TAG_LEN-1:0]             tag;
        logic [BLOCK_INDEX_BIT_LEN-1:0] index;
    } block_addr_t;

    typedef struct packed {
        logic                                      valid;
        logic [UUID_SIZE-1:0]                      uuid;
        block_addr_t                               block_addr;
        logic [BLOCK_SIZE-1:0]                     write_status;
        logic [BLOCK_SIZE-1:0][CACHE_RW_SIZE-1:0]  write_block;
    } mshr_reg_t;

    typedef struct packed {
        logic                                      valid;
        logic                                      dirty;
        logic [TAG_LEN-1:0]                        tag;
        logic [BLOCK_SIZE-1:0][CACHE_RW_SIZE-1:0]  block;
    } cache_frame_t;

    typedef struct packed {
        logic                     hit;
        logic [CACHE_RW_SIZE-1:0] data;
        logic                     uuid_ready;
        logic [UUID_SIZE-1:0]     uuid;
    } cache_resp_t;

    typedef enum logic [1:0] {
        START,
        BLOCK_PULL,
        VICTIM_EJECT,
        FINISH
    } bank_state_e;

    // ########################################################################
    // wishbone classic
    // ########################################################################
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat_r;
        logic        ack;
    } wb_rsp_t;

endpackage

`default_nettype wire
